/* source/polar_alu_consts.svh */
// ----------------------------------------------------------
// Polar ALU constants
// Datapath and lane geometry, polar saturation bound, opcode
// width and the APB register offsets
// ----------------------------------------------------------
`ifndef POLAR_ALU_CONSTS_SVH
`define POLAR_ALU_CONSTS_SVH

// Datapath geometry
`define XLEN        32
`define LANE_W      8
`define LANES       4

// Polar saturation, the negative bound is -`SAT_MAX
`define SAT_MAX     (127)

`define ALU_OP_W    5

// APB register map
`define APB_ADDR_W  8
`define REG_OPA     8'h00
`define REG_OPB     8'h04
`define REG_IMM     8'h08
`define REG_OP      8'h0C
`define REG_RESULT  8'h10
`define REG_STATUS  8'h14

`endif

/* source/polar_alu_pkg.sv */
// ----------------------------------------------------------
// Polar ALU package
// Data word and lane types, the opcode encoding and the
// polar group test
// ----------------------------------------------------------
`default_nettype none

`include "polar_alu_consts.svh"

package polar_alu_pkg;

    typedef logic [`XLEN-1:0] xlen_t;

    // One signed lane of the polar unit
    typedef logic signed [`LANE_W-1:0] lane_t;

    typedef enum logic [`ALU_OP_W-1:0] {
        // Arithmetic and logic
        ADD = 5'd0,
        SUB,
        ANDL,
        ORL,
        XORL,
        // Shifts
        SLL,
        SRL,
        SRA,
        // Set less than
        SLTS,
        SLTU,
        // Branch comparisons
        EQ,
        NE,
        LTS,
        LTU,
        GES,
        GEU,
        // Polar lane ops
        PL_R,
        PL_F,
        PL_DECODE,
        PL_G
    } alu_op_e;

    function automatic logic is_polar(alu_op_e op);
        return (op == PL_R) || (op == PL_F) || (op == PL_DECODE) || (op == PL_G);
    endfunction

endpackage

`default_nettype wire

/* source/int_alu.sv */
// ----------------------------------------------------------
// Integer ALU
// Base RV32 operations: add/sub, logic, shifts, set less
// than, plus branch condition resolution
// ----------------------------------------------------------
`default_nettype none

`include "polar_alu_consts.svh"

module int_alu (
    input  polar_alu_pkg::xlen_t   operand_a_i,
    input  polar_alu_pkg::xlen_t   operand_b_i,
    input  polar_alu_pkg::alu_op_e op_i,
    output polar_alu_pkg::xlen_t   result_o,
    output logic                   branch_res_o
);
    import polar_alu_pkg::*;

    xlen_t                     operand_a_rev;

    logic                      adder_op_b_negate;
    logic [`XLEN:0]            adder_in_a;
    logic [`XLEN:0]            adder_in_b;
    logic [`XLEN:0]            adder_result_ext;
    xlen_t                     adder_result;
    logic                      adder_z_flag;

    logic [$clog2(`XLEN)-1:0]  shift_amt;
    logic                      shift_left;
    logic                      shift_arithmetic;
    xlen_t                     shift_op_a;
    logic [`XLEN:0]            shift_op_a_ext;
    logic [`XLEN:0]            shift_right_result;
    xlen_t                     shift_left_result;
    xlen_t                     shift_result;

    logic                      cmp_signed;
    logic                      less;

    // Bit reversal of A going in and of the shifter coming out
    for (genvar k = 0; k < `XLEN; k++) begin : g_rev
        assign operand_a_rev[k]     = operand_a_i[`XLEN-1-k];
        assign shift_left_result[k] = shift_right_result[`XLEN-1-k];
    end

    // ------------------------------------------------------------
    // Adder
    // ------------------------------------------------------------
    assign adder_op_b_negate = (op_i == SUB) || (op_i == EQ) || (op_i == NE);

    // Carry-in rides in the extra low bit
    assign adder_in_a       = {operand_a_i, 1'b1};
    assign adder_in_b       = {operand_b_i, 1'b0} ^ {(`XLEN+1){adder_op_b_negate}};
    assign adder_result_ext = adder_in_a + adder_in_b;
    assign adder_result     = adder_result_ext[`XLEN:1];
    assign adder_z_flag     = ~|adder_result;

    // ------------------------------------------------------------
    // Shifter
    // ------------------------------------------------------------
    assign shift_amt        = operand_b_i[$clog2(`XLEN)-1:0];
    assign shift_left       = (op_i == SLL);
    assign shift_arithmetic = (op_i == SRA);

    // Left shifts go through the right shifter on reversed bits
    assign shift_op_a         = shift_left ? operand_a_rev : operand_a_i;
    assign shift_op_a_ext     = {shift_arithmetic & shift_op_a[`XLEN-1], shift_op_a};
    assign shift_right_result = $unsigned($signed(shift_op_a_ext) >>> shift_amt);

    assign shift_result = shift_left ? shift_left_result : shift_right_result[`XLEN-1:0];

    // ------------------------------------------------------------
    // Comparison
    // ------------------------------------------------------------
    assign cmp_signed = (op_i == SLTS) || (op_i == LTS) || (op_i == GES);

    assign less = $signed({cmp_signed & operand_a_i[`XLEN-1], operand_a_i})
                < $signed({cmp_signed & operand_b_i[`XLEN-1], operand_b_i});

    // Branch outcome, non-branch opcodes read as taken
    always_comb begin
        case (op_i)
            EQ:       branch_res_o = adder_z_flag;
            NE:       branch_res_o = ~adder_z_flag;
            LTS, LTU: branch_res_o = less;
            GES, GEU: branch_res_o = ~less;
            default:  branch_res_o = 1'b1;
        endcase
    end

    // Result mux
    always_comb begin
        case (op_i)
            ADD, SUB:      result_o = adder_result;
            ANDL:          result_o = operand_a_i & operand_b_i;
            ORL:           result_o = operand_a_i | operand_b_i;
            XORL:          result_o = operand_a_i ^ operand_b_i;
            SLL, SRL, SRA: result_o = shift_result;
            SLTS, SLTU:    result_o = {{(`XLEN-1){1'b0}}, less};
            default:       result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/polar_simd.sv */
// ----------------------------------------------------------
// Polar SIMD unit
// Four signed 8-bit lanes computing the polar R, F, DECODE
// and G functions, G with saturation to +/-127
// ----------------------------------------------------------
`default_nettype none

`include "polar_alu_consts.svh"

module polar_simd (
    input  polar_alu_pkg::xlen_t   operand_a_i,
    input  polar_alu_pkg::xlen_t   operand_b_i,
    input  polar_alu_pkg::xlen_t   imm_i,
    input  polar_alu_pkg::alu_op_e op_i,
    output polar_alu_pkg::xlen_t   result_o
);
    import polar_alu_pkg::*;

    xlen_t func_r;
    xlen_t func_f;
    xlen_t func_decode;
    xlen_t func_g;

    // Lane 0 sits in bits 7:0
    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        lane_t                   lane_a;
        lane_t                   lane_b;
        logic [`LANE_W-1:0]      lane_imm;
        logic [`LANE_W-1:0]      abs_a;
        logic [`LANE_W-1:0]      abs_b;
        logic [`LANE_W-1:0]      mag_min;
        logic                    sign_diff;
        logic signed [`LANE_W:0] sum_ab;
        logic signed [`LANE_W:0] diff_ba;
        logic signed [`LANE_W:0] g_raw;
        lane_t                   g_sat;

        assign lane_a   = operand_a_i[i*`LANE_W +: `LANE_W];
        assign lane_b   = operand_b_i[i*`LANE_W +: `LANE_W];
        assign lane_imm = imm_i[i*`LANE_W +: `LANE_W];

        // R: sign of a, forced to zero when b is one
        assign func_r[i*`LANE_W +: `LANE_W] = (lane_b == lane_t'(1)) ? '0
                                            : {{(`LANE_W-1){1'b0}}, lane_a[`LANE_W-1]};

        assign func_decode[i*`LANE_W +: `LANE_W] = (lane_b == '0) ? lane_a : '0;

        // F: min magnitude with the product sign
        // abs(-128) wraps to 0x80, which is the largest unsigned value
        assign abs_a     = lane_a[`LANE_W-1] ? -lane_a : lane_a;
        assign abs_b     = lane_b[`LANE_W-1] ? -lane_b : lane_b;
        assign mag_min   = (abs_a > abs_b) ? abs_b : abs_a;
        assign sign_diff = lane_a[`LANE_W-1] ^ lane_b[`LANE_W-1];

        assign func_f[i*`LANE_W +: `LANE_W] = sign_diff ? -mag_min : mag_min;

        // ------------------------------------------------------------
        // G: a+b or b-a, one extra bit for the overflow
        // ------------------------------------------------------------
        assign sum_ab  = lane_a + lane_b;
        assign diff_ba = lane_b - lane_a;
        assign g_raw   = (lane_imm == '0) ? sum_ab : diff_ba;

        assign g_sat = (g_raw > `SAT_MAX)  ? lane_t'(`SAT_MAX)
                     : (g_raw < -`SAT_MAX) ? lane_t'(-`SAT_MAX)
                     : g_raw[`LANE_W-1:0];

        assign func_g[i*`LANE_W +: `LANE_W] = g_sat;

        // The symmetric clamp never lets -128 out of a G lane
        always_comb begin
            if (op_i == PL_G) begin
                assert (result_o[i*`LANE_W +: `LANE_W] != 8'h80)
                    else $error("polar_simd: PL_G lane %0d produced 0x80", i);
            end
        end
    end

    // Output mux
    always_comb begin
        case (op_i)
            PL_R:      result_o = func_r;
            PL_F:      result_o = func_f;
            PL_DECODE: result_o = func_decode;
            PL_G:      result_o = func_g;
            default:   result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/result_select.sv */
// ----------------------------------------------------------
// Result stage
// Picks the integer or polar result on start and registers
// it with the branch flag and a valid bit
// ----------------------------------------------------------
`default_nettype none

module result_select (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  polar_alu_pkg::alu_op_e op_i,
    input  logic                   start_i,
    input  polar_alu_pkg::xlen_t   int_result_i,
    input  polar_alu_pkg::xlen_t   polar_result_i,
    input  logic                   branch_res_i,
    output polar_alu_pkg::xlen_t   result_o,
    output logic                   branch_o,
    output logic                   valid_o
);
    import polar_alu_pkg::*;

    xlen_t result_next;
    xlen_t result_q;
    logic  branch_q;
    logic  valid_q;

    assign result_next = is_polar(op_i) ? polar_result_i : int_result_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            result_q <= '0;
            branch_q <= 1'b0;
            valid_q  <= 1'b0;
        end else if (start_i) begin
            result_q <= result_next;
            branch_q <= branch_res_i;
            valid_q  <= 1'b1;
        end
    end

    // Valid reads low for the whole cycle a computation is pending
    assign valid_o  = valid_q & ~start_i;
    assign result_o = result_q;
    assign branch_o = branch_q;

    // Valid only comes up on the edge right after a start pulse
    a_valid_after_start: assert property (
        @(posedge clk_i) disable iff (reset_i)
        $rose(valid_o) |-> $past(start_i)
    ) else $error("result_select: valid rose without a start one cycle earlier");

endmodule

`default_nettype wire

/* source/polar_alu_apb.sv */
// ----------------------------------------------------------
// Polar ALU top level
// APB3 slave with zero wait states, holding the operand, imm
// and opcode registers and exposing the registered result
// and status of the integer and polar datapaths
// ----------------------------------------------------------
`default_nettype none

`include "polar_alu_consts.svh"

module polar_alu_apb (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   psel_i,
    input  logic                   penable_i,
    input  logic                   pwrite_i,
    input  logic [`APB_ADDR_W-1:0] paddr_i,
    input  polar_alu_pkg::xlen_t   pwdata_i,
    output polar_alu_pkg::xlen_t   prdata_o,
    output logic                   pready_o,
    output logic                   pslverr_o
);
    import polar_alu_pkg::*;

    xlen_t   opa_q;
    xlen_t   opb_q;
    xlen_t   imm_q;
    alu_op_e op_q;
    logic    start_q;

    logic    apb_access;
    logic    apb_write;
    logic    apb_read;
    logic    sel_opa;
    logic    sel_opb;
    logic    sel_imm;
    logic    sel_op;
    logic    sel_result;
    logic    sel_status;
    logic    addr_hit;
    xlen_t   rdata;

    xlen_t   int_result;
    logic    branch_res;
    xlen_t   polar_result;
    xlen_t   result;
    logic    branch_flag;
    logic    valid;

    // ------------------------------------------------------------
    // APB decode
    // ------------------------------------------------------------
    assign apb_access = psel_i & penable_i;
    assign apb_write  = apb_access & pwrite_i;
    assign apb_read   = apb_access & ~pwrite_i;

    assign sel_opa    = (paddr_i == `REG_OPA);
    assign sel_opb    = (paddr_i == `REG_OPB);
    assign sel_imm    = (paddr_i == `REG_IMM);
    assign sel_op     = (paddr_i == `REG_OP);
    assign sel_result = (paddr_i == `REG_RESULT);
    assign sel_status = (paddr_i == `REG_STATUS);

    assign addr_hit = sel_opa | sel_opb | sel_imm | sel_op | sel_result | sel_status;

    // No back-pressure
    assign pready_o = 1'b1;

    // Unmapped address, or a write to a read-only register
    assign pslverr_o = apb_access & (~addr_hit | (pwrite_i & (sel_result | sel_status)));

    // ------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            opa_q   <= '0;
            opb_q   <= '0;
            imm_q   <= '0;
            op_q    <= ADD;
            start_q <= 1'b0;
        end else begin
            // An opcode write kicks off one computation
            start_q <= apb_write & sel_op;
            if (apb_write & sel_opa) begin
                opa_q <= pwdata_i;
            end
            if (apb_write & sel_opb) begin
                opb_q <= pwdata_i;
            end
            if (apb_write & sel_imm) begin
                imm_q <= pwdata_i;
            end
            if (apb_write & sel_op) begin
                op_q <= alu_op_e'(pwdata_i[`ALU_OP_W-1:0]);
            end
        end
    end

    // Read mux
    always_comb begin
        case (paddr_i)
            `REG_OPA:    rdata = opa_q;
            `REG_OPB:    rdata = opb_q;
            `REG_IMM:    rdata = imm_q;
            `REG_OP:     rdata = {{(`XLEN-`ALU_OP_W){1'b0}}, op_q};
            `REG_RESULT: rdata = result;
            `REG_STATUS: rdata = {{(`XLEN-2){1'b0}}, valid, branch_flag};
            default:     rdata = '0;
        endcase
    end

    assign prdata_o = apb_read ? rdata : '0;

    // ------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------
    int_alu u_int_alu (
        .operand_a_i  (opa_q),
        .operand_b_i  (opb_q),
        .op_i         (op_q),
        .result_o     (int_result),
        .branch_res_o (branch_res)
    );

    polar_simd u_polar_simd (
        .operand_a_i (opa_q),
        .operand_b_i (opb_q),
        .imm_i       (imm_q),
        .op_i        (op_q),
        .result_o    (polar_result)
    );

    result_select u_result_select (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .op_i           (op_q),
        .start_i        (start_q),
        .int_result_i   (int_result),
        .polar_result_i (polar_result),
        .branch_res_i   (branch_res),
        .result_o       (result),
        .branch_o       (branch_flag),
        .valid_o        (valid)
    );

    // Errors are only signalled inside an access phase
    a_pslverr_in_access: assert property (
        @(posedge clk_i) disable iff (reset_i)
        pslverr_o |-> (psel_i && penable_i)
    ) else $error("polar_alu_apb: pslverr outside an APB access cycle");

endmodule

`default_nettype wire

/* verif/polar_alu_tb.sv */
// ----------------------------------------------------------
// Polar ALU testbench
// Drives the APB slave through reset, integer, branch, polar
// and protocol tests against a behavioral model
// ----------------------------------------------------------
`default_nettype none

`include "polar_alu_consts.svh"

module polar_alu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import polar_alu_pkg::*;

    localparam int RESET_CYCLES   = 16;
    localparam int INT_RANDOM     = 200;
    localparam int POLAR_RANDOM   = 40;
    // APB transfers per test
    localparam int RESET_XFERS    = 2;
    localparam int INT_XFERS      = (INT_RANDOM + 6) * 5;
    localparam int BRANCH_XFERS   = (6 * 10 + 3) * 5;
    localparam int POLAR_XFERS    = 4 * (POLAR_RANDOM + 2) * 5;
    localparam int PROTOCOL_XFERS = 8;
    localparam int TOTAL_XFERS    = RESET_XFERS + INT_XFERS + BRANCH_XFERS
                                  + POLAR_XFERS + PROTOCOL_XFERS;
    // Two cycles per transfer with a 1.5x margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 3 * TOTAL_XFERS;

    logic                   clk;
    logic                   reset;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    xlen_t                  pwdata;
    xlen_t                  prdata;
    logic                   pready;
    logic                   pslverr;

    integer seed            = 32'hc1d3_0e43;
    int     value_errors    = 0;
    int     protocol_errors = 0;
    int     cycle_count     = 0;

    polar_alu_apb dut (
        .clk_i     (clk),
        .reset_i   (reset),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic xlen_t model_int(alu_op_e op, xlen_t a, xlen_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            ANDL:    return a & b;
            ORL:     return a | b;
            XORL:    return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SRA:     return $signed(a) >>> b[4:0];
            SLTS:    return {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    return {{(`XLEN-1){1'b0}}, a < b};
            default: return '0;
        endcase
    endfunction

    function automatic logic model_branch(alu_op_e op, xlen_t a, xlen_t b);
        case (op)
            EQ:      return a == b;
            NE:      return a != b;
            LTS:     return $signed(a) < $signed(b);
            LTU:     return a < b;
            GES:     return $signed(a) >= $signed(b);
            GEU:     return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic xlen_t model_polar(alu_op_e op, xlen_t a, xlen_t b, xlen_t imm);
        xlen_t                    res;
        logic signed [`LANE_W-1:0] la;
        logic signed [`LANE_W-1:0] lb;
        logic [`LANE_W-1:0]        mag_a;
        logic [`LANE_W-1:0]        mag_b;
        logic [`LANE_W-1:0]        mag;
        int                        g;
        int                        i;
        res = '0;
        for (i = 0; i < `LANES; i++) begin
            la = a[i*`LANE_W +: `LANE_W];
            lb = b[i*`LANE_W +: `LANE_W];
            mag_a = (la < 0) ? 8'(-int'(la)) : la;
            mag_b = (lb < 0) ? 8'(-int'(lb)) : lb;
            mag = (mag_a > mag_b) ? mag_b : mag_a;
            if (imm[i*`LANE_W +: `LANE_W] == 0) begin
                g = int'(la) + int'(lb);
            end else begin
                g = int'(lb) - int'(la);
            end
            g = (g > `SAT_MAX) ? `SAT_MAX : (g < -`SAT_MAX) ? -`SAT_MAX : g;
            case (op)
                PL_R:      res[i*`LANE_W +: `LANE_W] = (lb == 1) ? 8'h00 : ((la < 0) ? 8'h01 : 8'h00);
                PL_DECODE: res[i*`LANE_W +: `LANE_W] = (lb == 0) ? la : 8'h00;
                PL_F:      res[i*`LANE_W +: `LANE_W] = ((la < 0) != (lb < 0)) ? 8'(-int'(mag)) : mag;
                PL_G:      res[i*`LANE_W +: `LANE_W] = 8'(g);
                default:   res[i*`LANE_W +: `LANE_W] = 8'h00;
            endcase
        end
        return res;
    endfunction

    // ------------------------------------------------------------
    // Checks and APB access
    // ------------------------------------------------------------
    task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
        assert (act === exp) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        assert (ok === 1'b1) else begin
            $display("Error: %s", what);
            protocol_errors++;
        end
    endtask

    // Setup then access, sampled mid access cycle
    task automatic apb_transfer(input logic write, input logic [`APB_ADDR_W-1:0] addr,
                                input xlen_t wdata, input logic exp_err, output xlen_t rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        check_flag(pready, "pready was low in an access cycle");
        check_flag(pslverr === exp_err,
                   $sformatf("pslverr was %b at address %h, expected %b", pslverr, addr, exp_err));
    endtask

    task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr, input xlen_t data,
                             input logic exp_err);
        xlen_t unused_rdata;
        apb_transfer(1'b1, addr, data, exp_err, unused_rdata);
    endtask

    task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr, input logic exp_err,
                            output xlen_t data);
        apb_transfer(1'b0, addr, '0, exp_err, data);
    endtask

    task automatic apb_idle();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic compute(input alu_op_e op, input xlen_t a, input xlen_t b, input xlen_t imm);
        apb_write(`REG_OPA, a, 1'b0);
        apb_write(`REG_OPB, b, 1'b0);
        apb_write(`REG_IMM, imm, 1'b0);
        apb_write(`REG_OP, xlen_t'(op), 1'b0);
    endtask

    task automatic check_result(input string name, input xlen_t exp);
        xlen_t rdata;
        apb_read(`REG_RESULT, 1'b0, rdata);
        check_value(name, exp, rdata);
    endtask

    task automatic check_status(input string name, input logic exp_branch);
        xlen_t rdata;
        apb_read(`REG_STATUS, 1'b0, rdata);
        check_flag(rdata[1], $sformatf("valid was clear after the OP write of %s", name));
        check_value(name, xlen_t'(exp_branch), xlen_t'(rdata[0]));
    endtask

    // Each lane random or one of the corner values
    function automatic xlen_t random_lanes();
        logic [`LANE_W-1:0] corner [4] = '{8'h80, 8'h7F, 8'h01, 8'h00};
        xlen_t              word;
        int                 i;
        for (i = 0; i < `LANES; i++) begin
            if ($random(seed) & 1) begin
                word[i*`LANE_W +: `LANE_W] = corner[$random(seed) & 3];
            end else begin
                word[i*`LANE_W +: `LANE_W] = 8'($random(seed));
            end
        end
        return word;
    endfunction

    function automatic xlen_t random_imm();
        xlen_t word;
        int    i;
        for (i = 0; i < `LANES; i++) begin
            word[i*`LANE_W +: `LANE_W] = ($random(seed) & 1) ? 8'h00 : (8'($random(seed)) | 8'h01);
        end
        return word;
    endfunction

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic test_reset();
        xlen_t rdata;
        apb_read(`REG_RESULT, 1'b0, rdata);
        check_value("reset RESULT", '0, rdata);
        apb_read(`REG_STATUS, 1'b0, rdata);
        check_value("reset STATUS", '0, rdata);
    endtask

    task automatic test_integer();
        alu_op_e op;
        xlen_t   a;
        xlen_t   b;
        int      i;
        for (i = 0; i < INT_RANDOM; i++) begin
            op = alu_op_e'(5'(i % 10));
            a = $random(seed);
            b = $random(seed);
            compute(op, a, b, '0);
            check_result($sformatf("%s #%0d", op.name(), i), model_int(op, a, b));
        end
        // Shift amounts 0 and 31 with random upper bits in B
        for (i = 0; i < 6; i++) begin
            op = alu_op_e'(5'(int'(SLL) + i / 2));
            a = $random(seed);
            b = $random(seed);
            b[4:0] = (i % 2) ? 5'd31 : 5'd0;
            compute(op, a, b, '0);
            check_result($sformatf("%s by %0d", op.name(), b[4:0]), model_int(op, a, b));
        end
    endtask

    task automatic test_branches();
        alu_op_e branch_ops [6] = '{EQ, NE, LTS, LTU, GES, GEU};
        alu_op_e other_ops [3]  = '{ADD, XORL, PL_G};
        xlen_t   a;
        xlen_t   b;
        int      i;
        int      k;
        for (i = 0; i < 6; i++) begin
            for (k = 0; k < 10; k++) begin
                a = $random(seed);
                b = $random(seed);
                if (k == 0) begin
                    b = a;
                end else if (k == 1) begin
                    a[`XLEN-1] = 1'b1;
                    b[`XLEN-1] = 1'b0;
                end else if (k == 2) begin
                    a[`XLEN-1] = 1'b0;
                    b[`XLEN-1] = 1'b1;
                end
                compute(branch_ops[i], a, b, '0);
                check_status($sformatf("%s case %0d", branch_ops[i].name(), k),
                             model_branch(branch_ops[i], a, b));
            end
        end
        for (i = 0; i < 3; i++) begin
            compute(other_ops[i], $random(seed), $random(seed), '0);
            check_status($sformatf("%s branch flag", other_ops[i].name()), 1'b1);
        end
    endtask

    task automatic test_polar();
        alu_op_e polar_ops [4] = '{PL_R, PL_F, PL_DECODE, PL_G};
        xlen_t   a;
        xlen_t   b;
        xlen_t   imm;
        int      i;
        int      k;
        for (i = 0; i < 4; i++) begin
            for (k = 0; k < POLAR_RANDOM + 2; k++) begin
                if (k == 0) begin
                    // Both saturation bounds and an exact zero
                    a = 32'h7F80_7F80;
                    b = 32'h7F80_0180;
                    imm = 32'h0000_0101;
                end else if (k == 1) begin
                    a = 32'h0001_8000;
                    b = 32'h7F00_0001;
                    imm = 32'hFF00_FF00;
                end else begin
                    a = random_lanes();
                    b = random_lanes();
                    imm = random_imm();
                end
                compute(polar_ops[i], a, b, imm);
                check_result($sformatf("%s a=%h b=%h imm=%h", polar_ops[i].name(), a, b, imm),
                             model_polar(polar_ops[i], a, b, imm));
            end
        end
    endtask

    task automatic test_protocol();
        xlen_t a;
        xlen_t b;
        xlen_t rdata;
        a = 32'h1234_5678;
        b = 32'h0101_0101;
        compute(ADD, a, b, '0);
        check_status("protocol ADD", 1'b1);
        apb_read(8'h18, 1'b1, rdata);
        check_value("unmapped read data", '0, rdata);
        apb_write(`REG_RESULT, 32'hFFFF_FFFF, 1'b1);
        check_result("RESULT after write", model_int(ADD, a, b));
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        test_reset();
        test_integer();
        test_branches();
        test_polar();
        test_protocol();
        apb_idle();
        repeat (2) @(posedge clk);

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* polar_alu.f */
+incdir+source
source/polar_alu_pkg.sv
source/int_alu.sv
source/polar_simd.sv
source/result_select.sv
source/polar_alu_apb.sv
verif/polar_alu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the polar ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f polar_alu.f --top-module polar_alu_tb \
    -Mdir obj_dir -o polar_alu_sim

# Keep the output even if the simulator exits with an error
sim_output=$(./obj_dir/polar_alu_sim) || true
echo "$sim_output"

if grep -q "TESTS PASSED" <<< "$sim_output"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
